//--- hdl/pe_pkg.sv
/* Processing element shared types */
`default_nettype none

package pe_pkg;

    localparam int DATA_W       = 8;    // ifmap and weight values
    localparam int PROD_W       = 16;   // Full product width
    localparam int PSUM_W       = 16;   // Partial sums wrap at this width
    localparam int NUM_FILTERS  = 4;
    localparam int FILTER_LEN   = 3;    // Taps per filter
    localparam int SECTION_LEN  = 4;    // Entries per section, lanes per packet
    localparam int NUM_SECTIONS = 3;
    localparam int SPAD_DEPTH   = 12;   // NUM_SECTIONS * SECTION_LEN
    localparam int OFMAP_LEN    = 14;   // Stride 1 over 16 inputs

    typedef logic signed [DATA_W-1:0] data_t;

    // Filter packets carry {slot, row}
    typedef struct packed {
        logic [1:0] slot;
        logic [2:0] row;
    } filt_idx_t;

    // Same 5 bits, ifmap packets use the whole word as row
    typedef union packed {
        filt_idx_t  filt;
        logic [4:0] ifm;
    } pkt_idx_u;

    typedef struct packed {
        logic                    valid;
        pkt_idx_u                idx;
        data_t [SECTION_LEN-1:0] data;   // Lane 0 in the low bits
    } pe_packet_t;

    typedef struct packed {
        logic                     valid;
        logic [1:0]               filter_idx;
        logic signed [PSUM_W-1:0] psum;
    } psum_packet_t;

    // One issued multiply
    typedef struct packed {
        logic       valid;
        data_t      ifdata;
        data_t      weight;
        logic [1:0] filter_idx;
        logic       first_tap;   // Restart accumulator
        logic       last_tap;    // Result complete after this one
    } mac_op_t;

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_DRAIN} pe_state_e;

endpackage

`default_nettype wire

//--- hdl/pe_ctrl.sv
/* Run controller */
`default_nettype none

module pe_ctrl import pe_pkg::*; (
    input  wire  clk,
    input  wire  rst,
    input  wire  conv_continue,   // Start pulse from the array
    input  wire  last_issue,      // Final op leaves the counters
    input  wire  pipe_empty,
    input  wire  slots_empty,
    output logic run,
    output logic load_en,
    output logic clear,
    output logic conv_done
);

    pe_state_e state, state_n;

    always_comb begin
        state_n = state;
        case (state)
            ST_IDLE:  if (conv_continue) state_n = ST_RUN;
            ST_RUN:   if (last_issue) state_n = ST_DRAIN;
            ST_DRAIN: if (pipe_empty && slots_empty) state_n = ST_IDLE;   // All taken
            default:  state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) state <= ST_IDLE;
        else     state <= state_n;
    end

    assign clear     = (state == ST_IDLE) && conv_continue;   // One cycle, with the start
    assign run       = (state == ST_RUN);
    assign load_en   = (state == ST_IDLE);   // Filters only between runs
    assign conv_done = (state == ST_IDLE);

endmodule

`default_nettype wire

//--- hdl/pe_counter.sv
/* Convolution step counters */
`default_nettype none

module pe_counter import pe_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        clear,
    input  wire        run,
    input  wire        tap_ready,     // Window data present
    input  wire        accum_stall,   // Output slots backed up
    output logic       step,
    output logic [1:0] filter_idx,
    output logic [1:0] tap,
    output logic       first_tap,
    output logic       last_tap,
    output logic       window_adv,
    output logic       last_issue
);

    logic [3:0] pos;          // Output position 0..13
    logic       filt_wrap;

    assign step       = run && tap_ready && !accum_stall;
    assign filt_wrap  = (filter_idx == 2'(NUM_FILTERS - 1));
    assign first_tap  = (tap == 2'd0);
    assign last_tap   = (tap == 2'(FILTER_LEN - 1));
    assign window_adv = step && filt_wrap && last_tap;        // Slide by one input
    assign last_issue = window_adv && (pos == 4'(OFMAP_LEN - 1));

    // Filter fastest, then tap, then position
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            filter_idx <= '0;
            tap        <= '0;
            pos        <= '0;
        end else if (step) begin
            filter_idx <= filt_wrap ? 2'd0 : filter_idx + 2'd1;
            if (filt_wrap) begin
                tap <= last_tap ? 2'd0 : tap + 2'd1;
                if (last_tap)
                    pos <= (pos == 4'(OFMAP_LEN - 1)) ? 4'd0 : pos + 4'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/filter_spad.sv
/* Filter scratch pad */
`default_nettype none

module filter_spad import pe_pkg::*; #(
    parameter int unsigned pe_row = 0
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             load_en,
    input  wire pe_packet_t filter_packet,
    input  wire logic [1:0] filter_idx,
    input  wire logic [1:0] tap,
    output data_t           weight
);

    data_t [NUM_FILTERS-1:0][FILTER_LEN-1:0] weights;
    logic hit;

    // Filter view of the index, row must match ours
    assign hit = load_en && filter_packet.valid
              && (filter_packet.idx.filt.row == 3'(pe_row));

    always_ff @(posedge clk) begin
        if (rst)
            weights <= '0;
        else if (hit)
            for (int k = 0; k < FILTER_LEN; k++)   // Lane 3 unused
                weights[filter_packet.idx.filt.slot][k] <= filter_packet.data[k];
    end

    assign weight = weights[filter_idx][tap];   // Current filter and tap

endmodule

`default_nettype wire

//--- hdl/ifmap_spad.sv
/* Sectioned ifmap scratch pad */
`default_nettype none

module ifmap_spad import pe_pkg::*; #(
    parameter int unsigned pe_row = 0
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             clear,
    input  wire             run,
    input  wire pe_packet_t ifmap_packet,
    input  wire             step,
    input  wire logic [1:0] tap,
    input  wire             window_adv,
    input  wire logic [1:0] filter_idx,
    output data_t           ifdata,
    output logic            tap_ready,
    output logic            full
);

    data_t ram [SPAD_DEPTH];
    logic [NUM_SECTIONS-1:0] sec_valid;   // Section holds unconsumed data
    logic [NUM_SECTIONS-1:0] free_mask;
    logic [NUM_SECTIONS-1:0] avail;       // Valid after this cycle's free
    logic [NUM_SECTIONS-1:0] wr_mask;
    logic [3:0] start_ptr, next_start, read_ptr;
    logic [4:0] read_sum;
    logic [1:0] wr_sec;                   // Next section to fill, 0 1 2 0
    logic       accept;

    ////////////////////////////////////////
    // Window pointers
    assign next_start = (start_ptr == 4'(SPAD_DEPTH - 1)) ? 4'd0 : start_ptr + 4'd1;
    assign read_sum   = start_ptr + tap;
    assign read_ptr   = (read_sum >= 5'(SPAD_DEPTH)) ? 4'(read_sum - 5'(SPAD_DEPTH))
                                                      : read_sum[3:0];
    assign ifdata     = ram[read_ptr];
    assign tap_ready  = sec_valid[read_ptr[3:2]];   // Stall on a hole

    // Old section done once filter 0 reads the next section's first entry
    always_comb begin
        free_mask = '0;
        if (step && filter_idx == 2'd0 && next_start[1:0] == 2'b00
            && read_ptr == next_start)
            free_mask[start_ptr[3:2]] = 1'b1;
    end

    ////////////////////////////////////////
    // Section fill
    assign avail  = sec_valid & ~free_mask;
    assign full   = &avail;                 // Freed section is open this cycle
    assign accept = run && ifmap_packet.valid && !full
                 && (ifmap_packet.idx.ifm == 5'(pe_row));

    always_comb begin
        wr_mask = '0;
        if (accept) wr_mask[wr_sec] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            sec_valid <= '0;
            start_ptr <= '0;
            wr_sec    <= '0;
        end else begin
            sec_valid <= avail | wr_mask;
            if (window_adv) start_ptr <= next_start;
            if (accept) wr_sec <= (wr_sec == 2'(NUM_SECTIONS - 1)) ? 2'd0 : wr_sec + 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            for (int i = 0; i < SECTION_LEN; i++)
                ram[wr_sec * SECTION_LEN + i] <= ifmap_packet.data[i];
    end

endmodule

`default_nettype wire

//--- hdl/mac_pipe.sv
/* Multiply-accumulate pipeline */
`default_nettype none

module mac_pipe import pe_pkg::*; (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       clear,
    input  wire                       step,
    input  wire data_t                ifdata,
    input  wire data_t                weight,
    input  wire logic [1:0]           filter_idx,
    input  wire                       first_tap,
    input  wire                       last_tap,
    input  wire                       accum_stall,   // Freezes every stage
    output logic                      result_valid,
    output logic [1:0]                result_filter,
    output logic signed [PSUM_W-1:0]  result,
    output logic                      pipe_empty
);

    typedef struct packed {
        logic                     valid;
        logic signed [PROD_W-1:0] prod;
        logic [1:0]               filter_idx;
        logic                     first_tap;
        logic                     last_tap;
    } prod_op_t;

    mac_op_t  op_q;                              // Multiply register
    prod_op_t mul_q;                             // Product register
    logic signed [PROD_W-1:0] prod;
    logic signed [PSUM_W-1:0] acc [NUM_FILTERS]; // One running sum per filter
    logic signed [PSUM_W-1:0] acc_base;

    assign prod     = op_q.ifdata * op_q.weight;
    assign acc_base = mul_q.first_tap ? '0 : acc[mul_q.filter_idx];

    always_ff @(posedge clk) begin
        if (!accum_stall) begin
            op_q  <= '{step, ifdata, weight, filter_idx, first_tap, last_tap};
            mul_q <= '{op_q.valid, prod, op_q.filter_idx, op_q.first_tap, op_q.last_tap};
            if (mul_q.valid) acc[mul_q.filter_idx] <= acc_base + mul_q.prod;
            result_valid  <= mul_q.valid && mul_q.last_tap;   // Total ready
            result_filter <= mul_q.filter_idx;
        end
        if (clear)
            for (int f = 0; f < NUM_FILTERS; f++) acc[f] <= '0;
        if (rst || clear) begin
            op_q.valid   <= 1'b0;
            mul_q.valid  <= 1'b0;
            result_valid <= 1'b0;
        end
    end

    assign result     = acc[result_filter];   // Held while stalled
    assign pipe_empty = !op_q.valid && !mul_q.valid && !result_valid;

endmodule

`default_nettype wire

//--- hdl/psum_out_buf.sv
/* Output slots and vertical accumulation */
`default_nettype none

module psum_out_buf import pe_pkg::*; (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      result_valid,
    input  wire logic [1:0]          result_filter,
    input  wire logic signed [PSUM_W-1:0] result,
    input  wire psum_packet_t        psum_in,       // From neighbour PE
    input  wire                      psum_ack_in,   // Downstream took psum_out
    output psum_packet_t             psum_out,
    output logic                     psum_ack_out,
    output logic                     accum_stall,
    output logic                     slots_empty
);

    logic signed [PSUM_W-1:0] slot_data [NUM_FILTERS];
    logic signed [PSUM_W-1:0] vsum;
    logic [NUM_FILTERS-1:0] slot_ready;    // Slot holds a result
    logic [NUM_FILTERS-1:0] ready_freed;   // After this cycle's ack
    logic [NUM_FILTERS-1:0] ready_n;
    logic slot_wr;

    // Take psum_in when our slot is filled and the output register can move
    assign psum_ack_out = psum_in.valid && slot_ready[psum_in.filter_idx]
                       && (!psum_out.valid || psum_ack_in);

    always_comb begin
        ready_freed = slot_ready;
        if (psum_ack_out) ready_freed[psum_in.filter_idx] = 1'b0;
        ready_n = ready_freed;
        if (slot_wr) ready_n[result_filter] = 1'b1;
    end

    assign accum_stall = result_valid && ready_freed[result_filter];   // Slot still busy
    assign slot_wr     = result_valid && !accum_stall;
    assign slots_empty = ~|slot_ready;
    assign vsum        = psum_in.psum + slot_data[psum_in.filter_idx];

    always_ff @(posedge clk) begin
        if (rst) slot_ready <= '0;
        else     slot_ready <= ready_n;
    end

    always_ff @(posedge clk) begin
        if (slot_wr) slot_data[result_filter] <= result;
    end

    ////////////////////////////////////////
    // Output register, stable until acked
    always_ff @(posedge clk) begin
        if (psum_ack_out) begin
            psum_out.filter_idx <= psum_in.filter_idx;
            psum_out.psum       <= vsum;
        end
        if (rst)               psum_out.valid <= 1'b0;
        else if (psum_ack_out) psum_out.valid <= 1'b1;   // Reload wins over ack
        else if (psum_ack_in)  psum_out.valid <= 1'b0;
    end

endmodule

`default_nettype wire

//--- hdl/pe_top.sv
/* Processing element top */
`default_nettype none

module pe_top import pe_pkg::*; #(
    parameter int unsigned pe_row = 0   // Array row, 0 to 7
) (
    input  wire                clk,
    input  wire                rst,
    input  wire pe_packet_t    filter_packet,
    input  wire pe_packet_t    ifmap_packet,
    input  wire psum_packet_t  psum_in,
    input  wire                psum_ack_in,
    input  wire                conv_continue,
    output psum_packet_t       psum_out,
    output logic               psum_ack_out,
    output logic               conv_done,
    output logic               full
);

    logic run, load_en, clear, last_issue, pipe_empty, slots_empty;
    logic step, first_tap, last_tap, window_adv, tap_ready, accum_stall;
    logic [1:0] filter_idx, tap, result_filter;
    logic result_valid;
    logic signed [PSUM_W-1:0] result;
    data_t weight, ifdata;

    pe_ctrl u_ctrl (
        .clk, .rst, .conv_continue, .last_issue, .pipe_empty, .slots_empty,
        .run, .load_en, .clear, .conv_done
    );

    pe_counter u_counter (
        .clk, .rst, .clear, .run, .tap_ready, .accum_stall,
        .step, .filter_idx, .tap, .first_tap, .last_tap, .window_adv, .last_issue
    );

    filter_spad #(.pe_row(pe_row)) u_filter_spad (
        .clk, .rst, .load_en, .filter_packet, .filter_idx, .tap, .weight
    );

    ifmap_spad #(.pe_row(pe_row)) u_ifmap_spad (
        .clk, .rst, .clear, .run, .ifmap_packet, .step, .tap, .window_adv,
        .filter_idx, .ifdata, .tap_ready, .full
    );

    mac_pipe u_mac_pipe (
        .clk, .rst, .clear, .step, .ifdata, .weight, .filter_idx, .first_tap,
        .last_tap, .accum_stall, .result_valid, .result_filter, .result, .pipe_empty
    );

    psum_out_buf u_psum_out_buf (
        .clk, .rst, .result_valid, .result_filter, .result, .psum_in, .psum_ack_in,
        .psum_out, .psum_ack_out, .accum_stall, .slots_empty
    );

endmodule

`default_nettype wire

//--- tb/pe_chk.sv
/* Partial-sum handshake assertions */
`default_nettype none

module pe_chk import pe_pkg::*; (
    input wire               clk,
    input wire               rst,
    input wire psum_packet_t psum_in,
    input wire psum_packet_t psum_out,
    input wire               psum_ack_in,
    input wire               psum_ack_out
);

    int fail_count = 0;   // Assertion failures so far

    // Output register frozen until downstream takes it
    a_out_held: assert property (@(posedge clk) disable iff (rst)
        psum_out.valid && !psum_ack_in |=> $stable(psum_out))
    else begin
        fail_count++;
        $error("psum_out changed while waiting for ack");
    end

    a_ack_valid: assert property (@(posedge clk) disable iff (rst)
        psum_ack_out |-> psum_in.valid)   // Never ack an idle neighbour
    else begin
        fail_count++;
        $error("psum_ack_out raised without psum_in.valid");
    end

    a_reset_out: assert property (@(posedge clk) rst |=> !psum_out.valid)
    else begin
        fail_count++;
        $error("psum_out.valid high right after reset");
    end

endmodule

`default_nettype wire

//--- tb/pe_tb.sv
/* Processing element testbench */
`default_nettype none

module pe_tb import pe_pkg::*; ();

    localparam int ROW        = 2;
    localparam int NUM_CASES  = 3;
    localparam int NUM_OUT    = OFMAP_LEN * NUM_FILTERS;               // 56 per case
    localparam int MAX_CYCLES = 4 * NUM_CASES * (NUM_OUT * 4 + 100);

    // One table row
    typedef struct packed {
        data_t [15:0]                            ifm;
        data_t [NUM_FILTERS-1:0][FILTER_LEN-1:0] w;
        logic signed [PSUM_W-1:0]                base;       // Neighbour psum offset
        logic                                    throttle;   // Random ack stalls
    } case_t;

    logic         clk, rst, conv_continue, psum_ack_in;
    pe_packet_t   filter_packet, ifmap_packet;
    psum_packet_t psum_in, psum_out;
    logic         psum_ack_out, conv_done, full;
    case_t        cases [NUM_CASES];
    integer       seed;
    logic         throttle, saw_full;
    int           errors, checks;

    pe_top #(.pe_row(ROW)) u_dut (.*);

    bind pe_top pe_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Neighbour partial sum for output n
    function automatic logic [15:0] psum_value(input int c, input int n);
        return 16'(int'(cases[c].base) + n * 263);
    endfunction

    // Wrapped sum of psum_in and the dot product of window p with filter f
    function automatic logic [15:0] expected_psum(input int c, input int n);
        int acc;
        acc = int'(psum_value(c, n));
        for (int k = 0; k < FILTER_LEN; k++)
            acc += int'($signed(cases[c].ifm[n / 4 + k]))
                 * int'($signed(cases[c].w[n % 4][k]));
        return 16'(acc);
    endfunction

    ////////////////////////////////////////
    // Packet drivers
    task automatic load_filters(input int c);
        for (int f = 0; f < NUM_FILTERS; f++) begin
            @(negedge clk);
            filter_packet.valid         = 1'b1;
            filter_packet.idx.filt.slot = 2'(f);
            filter_packet.idx.filt.row  = 3'(ROW);
            for (int k = 0; k < FILTER_LEN; k++)
                filter_packet.data[k] = cases[c].w[f][k];
            filter_packet.data[3] = '0;
            @(negedge clk);
            filter_packet.idx.filt.row  = 3'(f + 3);   // Decoy into the loaded slot
            filter_packet.data          = $random(seed);
        end
        @(negedge clk);
        filter_packet = '0;
    endtask

    task automatic send_ifmap(input int c);
        for (int s = 0; s < 4; s++) begin
            @(negedge clk);
            ifmap_packet.valid   = 1'b1;
            ifmap_packet.idx.ifm = s[0] ? 5'd10 : 5'd18;   // Low bits still read as row 2
            ifmap_packet.data    = 32'h80ff_7f01 ^ 32'(s);
            @(negedge clk);
            ifmap_packet.idx.ifm = 5'(ROW);
            for (int i = 0; i < SECTION_LEN; i++)
                ifmap_packet.data[i] = cases[c].ifm[s * SECTION_LEN + i];
            @(posedge clk);
            while (full) begin                             // Held until a section frees
                if (s == 3) saw_full = 1'b1;
                @(posedge clk);
            end
        end
        @(negedge clk);
        ifmap_packet = '0;
    endtask

    task automatic send_psums(input int c);
        for (int n = 0; n < NUM_OUT; n++) begin
            @(negedge clk);
            psum_in.valid      = 1'b1;
            psum_in.filter_idx = 2'(n % 4);
            psum_in.psum       = psum_value(c, n);
            @(posedge clk);
            while (!psum_ack_out) @(posedge clk);
        end
        @(negedge clk);
        psum_in = '0;
    endtask

    task automatic collect_outputs(input int c);
        psum_packet_t held;
        logic         hold;
        int           n;
        hold = 1'b0;
        n    = 0;
        while (n < NUM_OUT) begin
            @(posedge clk);
            if (hold) check_value("psum_out held", 32'(psum_out), 32'(held));
            hold = psum_out.valid && !psum_ack_in;
            held = psum_out;
            if (psum_out.valid && psum_ack_in) begin   // Taken this cycle
                check_value("filter_idx", psum_out.filter_idx, n % 4);
                check_value("psum", $unsigned(psum_out.psum), expected_psum(c, n));
                n++;
            end
        end
    endtask

    // Random downstream ack in throttled cases
    initial begin
        integer r;
        forever begin
            @(negedge clk);
            if (throttle) begin
                r = $random(seed);
                psum_ack_in = r[0];
            end else begin
                psum_ack_in = 1'b1;
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the DUT did not finish within %0d cycles", cycles);
        $display("Simulation failed");
        $finish;
    end

    ////////////////////////////////////////
    // Main sequence
    initial begin
        seed = 32'hf360_dbe4;
        for (int i = 0; i < 16; i++) begin
            cases[0].ifm[i] = 8'(i * 3 - 20);                   // Ramp through zero
            cases[1].ifm[i] = 8'($random(seed));
            cases[2].ifm[i] = (i % 3 == 0) ? 8'sh7f : 8'sh80;   // Signed extremes
        end
        for (int f = 0; f < NUM_FILTERS; f++)
            for (int k = 0; k < FILTER_LEN; k++) begin
                cases[0].w[f][k] = 8'(f - k + 1);
                cases[1].w[f][k] = 8'($random(seed));
                cases[2].w[f][k] = ((f + k) % 2 == 1) ? 8'sh7f : 8'sh80;
            end
        cases[0].base = 16'sd100;
        cases[1].base = 16'($random(seed));
        cases[2].base = 16'sh8000;
        cases[0].throttle = 1'b0;
        cases[1].throttle = 1'b1;
        cases[2].throttle = 1'b0;

        rst = 1'b1;
        conv_continue = 1'b0;
        psum_ack_in = 1'b1;
        filter_packet = '0;
        ifmap_packet = '0;
        psum_in = '0;
        throttle = 1'b0;
        errors = 0;
        checks = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("conv_done after reset", conv_done, 1);
        check_value("full after reset", full, 0);
        check_value("psum_out.valid after reset", psum_out.valid, 0);

        for (int c = 0; c < NUM_CASES; c++) begin
            load_filters(c);
            @(negedge clk);
            conv_continue = 1'b1;
            throttle <= cases[c].throttle;
            @(negedge clk);
            conv_continue = 1'b0;
            check_value("conv_done after start", conv_done, 0);
            saw_full = 1'b0;
            fork
                send_ifmap(c);
                send_psums(c);
                collect_outputs(c);
            join
            check_value("full before fourth packet", saw_full, 1);
            throttle <= 1'b0;
            while (!conv_done) @(negedge clk);   // Drain back to idle
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, u_dut.u_chk.fail_count);
        if (errors == 0 && u_dut.u_chk.fail_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- pe.f
hdl/pe_pkg.sv
hdl/pe_ctrl.sv
hdl/pe_counter.sv
hdl/filter_spad.sv
hdl/ifmap_spad.sv
hdl/mac_pipe.sv
hdl/psum_out_buf.sv
hdl/pe_top.sv
tb/pe_chk.sv
tb/pe_tb.sv
